// File: hdl/cw_pkg.sv
`default_nettype none

package cw_pkg;

   localparam int USERIO_WIDTH   = 8;
   localparam int SYNC_STAGES    = 2;   // Strobe and pin input synchronizer depth
   localparam int FLASH_BIT      = 4;   // Counter bit for the error flash rate
   localparam int STATUS_ERR_BIT = 0;
   localparam int STATUS_PLL_BIT = 1;

   // Register map, one byte per register
   typedef enum logic [7:0] {
      TARGET_IO   = 8'h10,
      TARGET_PWR  = 8'h11,
      USERIO_DIR  = 8'h20,
      USERIO_DATA = 8'h21,
      USERIO_IN   = 8'h22,   // Read only
      STATUS      = 8'h30
   } reg_addr_e;

   // Internal register bus, rd and wr are single cycle pulses
   typedef struct packed {
      reg_addr_e   addr;
      logic [7:0]  wdata;
      logic        rd;
      logic        wr;
   } reg_bus_t;

   // Target pin control, same bit order as the TARGET_IO byte below power_off
   typedef struct packed {
      logic power_off;
      logic avrprog_en;
      logic nrst_en;
      logic nrst_val;
      logic pdid_en;
      logic pdid_val;
      logic pdic_en;
      logic pdic_val;
   } target_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/cw_top.sv
`timescale 1ns/1ps
`default_nettype none

module cw_top
   import cw_pkg::*;
(
   input  wire logic                     clk_usb_i,
   input  wire logic                     rst_i,

   // Host register bus
   input  wire logic [7:0]               usb_addr_i,
   input  wire logic [7:0]               usb_data_i,
   output logic      [7:0]               usb_data_o,
   output logic                          usb_data_oe_o,
   input  wire logic                     usb_rdn_i,
   input  wire logic                     usb_wrn_i,
   input  wire logic                     usb_cen_i,

   input  wire logic                     pll_status_i,
   output logic                          led_adc_o,
   output logic                          led_glitch_o,

   input  wire logic [USERIO_WIDTH-1:0]  userio_d_i,
   output logic      [USERIO_WIDTH-1:0]  userio_d_o,
   output logic      [USERIO_WIDTH-1:0]  userio_oe_o,

   // Target programming pins
   input  wire logic                     sam_mosi_i,
   input  wire logic                     sam_spck_i,
   output logic                          sam_miso_o,
   output logic                          sam_miso_oe_o,
   input  wire logic                     target_miso_i,
   output logic                          target_mosi_o,
   output logic                          target_sck_o,
   output logic                          target_spi_oe_o,
   output logic                          target_nrst_o,
   output logic                          target_nrst_oe_o,
   output logic                          target_pdid_o,
   output logic                          target_pdid_oe_o,
   output logic                          target_pdic_o,
   output logic                          target_pdic_oe_o,
   output logic                          target_poweron_o
);

   reg_bus_t     reg_bus;
   target_ctrl_t target_ctrl;
   logic [7:0]   read_data;
   logic [7:0]   read_data_target;
   logic [7:0]   read_data_userio;
   logic [7:0]   read_data_status;

   // Blocks return zero for addresses they do not own
   assign read_data = read_data_target | read_data_userio | read_data_status;

   usb_reg_bus U_usb_reg_bus (
      .clk_usb_i     (clk_usb_i),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .read_data_i   (read_data),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_bus_o     (reg_bus)
   );

   reg_target_io U_reg_target_io (
      .clk_usb_i     (clk_usb_i),
      .rst_i         (rst_i),
      .reg_bus_i     (reg_bus),
      .read_data_o   (read_data_target),
      .target_ctrl_o (target_ctrl)
   );

   target_pin_drive U_target_pin_drive (
      .target_ctrl_i    (target_ctrl),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdid_oe_o (target_pdid_oe_o),
      .target_pdic_o    (target_pdic_o),
      .target_pdic_oe_o (target_pdic_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_sck_o     (target_sck_o),
      .target_spi_oe_o  (target_spi_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o),
      .target_poweron_o (target_poweron_o)
   );

   reg_userio U_reg_userio (
      .clk_usb_i   (clk_usb_i),
      .rst_i       (rst_i),
      .reg_bus_i   (reg_bus),
      .userio_d_i  (userio_d_i),
      .userio_d_o  (userio_d_o),
      .userio_oe_o (userio_oe_o),
      .read_data_o (read_data_userio)
   );

   status_leds U_status_leds (
      .clk_usb_i    (clk_usb_i),
      .rst_i        (rst_i),
      .reg_bus_i    (reg_bus),
      .pll_status_i (pll_status_i),
      .read_data_o  (read_data_status),
      .led_adc_o    (led_adc_o),
      .led_glitch_o (led_glitch_o)
   );

endmodule

`default_nettype wire

// File: hdl/reg_target_io.sv
`timescale 1ns/1ps
`default_nettype none

module reg_target_io
   import cw_pkg::*;
(
   input  wire logic         clk_usb_i,
   input  wire logic         rst_i,
   input  wire reg_bus_t     reg_bus_i,
   output logic       [7:0]  read_data_o,
   output target_ctrl_t      target_ctrl_o
);

   logic [7:0] io_q;    // Bit 7 is a spare scratch bit
   logic [7:0] pwr_q;   // Bit 0 is power_off, upper bits scratch

   always_ff @(posedge clk_usb_i) begin
      if (rst_i) begin
         io_q  <= 8'h00;
         pwr_q <= 8'h00;   // Target powered after reset
      end else if (reg_bus_i.wr) begin
         case (reg_bus_i.addr)
            TARGET_IO:  io_q  <= reg_bus_i.wdata;
            TARGET_PWR: pwr_q <= reg_bus_i.wdata;
            default: ;
         endcase
      end
   end

   // Readback
   always_ff @(posedge clk_usb_i) begin
      if (rst_i)
         read_data_o <= 8'h00;
      else if (reg_bus_i.rd) begin
         case (reg_bus_i.addr)
            TARGET_IO:  read_data_o <= io_q;
            TARGET_PWR: read_data_o <= pwr_q;
            default:    read_data_o <= 8'h00;   // Not ours
         endcase
      end
   end

   assign target_ctrl_o = target_ctrl_t'({pwr_q[0], io_q[6:0]});

endmodule

`default_nettype wire

// File: hdl/reg_userio.sv
`timescale 1ns/1ps
`default_nettype none

module reg_userio
   import cw_pkg::*;
(
   input  wire logic                     clk_usb_i,
   input  wire logic                     rst_i,
   input  wire reg_bus_t                 reg_bus_i,
   input  wire logic [USERIO_WIDTH-1:0]  userio_d_i,
   output logic      [USERIO_WIDTH-1:0]  userio_d_o,
   output logic      [USERIO_WIDTH-1:0]  userio_oe_o,
   output logic      [7:0]               read_data_o
);

   logic [USERIO_WIDTH-1:0] dir_q;    // 1 drives the pin
   logic [USERIO_WIDTH-1:0] data_q;
   logic [USERIO_WIDTH-1:0] in_sync [SYNC_STAGES];

   always_ff @(posedge clk_usb_i) begin
      if (rst_i) begin
         dir_q  <= '0;
         data_q <= '0;
      end else if (reg_bus_i.wr) begin
         case (reg_bus_i.addr)
            USERIO_DIR:  dir_q  <= reg_bus_i.wdata[USERIO_WIDTH-1:0];
            USERIO_DATA: data_q <= reg_bus_i.wdata[USERIO_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // Header pins are asynchronous to the bus clock
   always_ff @(posedge clk_usb_i) begin
      in_sync[0] <= userio_d_i;
      for (int i = 1; i < SYNC_STAGES; i++)
         in_sync[i] <= in_sync[i-1];
   end

   always_ff @(posedge clk_usb_i) begin
      if (rst_i)
         read_data_o <= 8'h00;
      else if (reg_bus_i.rd) begin
         case (reg_bus_i.addr)
            USERIO_DIR:  read_data_o <= 8'(dir_q);
            USERIO_DATA: read_data_o <= 8'(data_q);
            USERIO_IN:   read_data_o <= 8'(in_sync[SYNC_STAGES-1]);
            default:     read_data_o <= 8'h00;
         endcase
      end
   end

   assign userio_oe_o = dir_q;
   assign userio_d_o  = data_q & dir_q;   // Undriven bits held low

endmodule

`default_nettype wire

// File: hdl/status_leds.sv
`timescale 1ns/1ps
`default_nettype none

module status_leds
   import cw_pkg::*;
(
   input  wire logic        clk_usb_i,
   input  wire logic        rst_i,
   input  wire reg_bus_t    reg_bus_i,
   input  wire logic        pll_status_i,
   output logic      [7:0]  read_data_o,
   output logic             led_adc_o,
   output logic             led_glitch_o
);

   logic               err_q;   // Sticky, set by a write nobody owns
   logic [FLASH_BIT:0] flash_cnt;
   logic               flash;

   function automatic logic addr_mapped(input reg_addr_e addr);
      case (addr)
         TARGET_IO, TARGET_PWR, USERIO_DIR, USERIO_DATA, USERIO_IN, STATUS:
            addr_mapped = 1'b1;
         default:
            addr_mapped = 1'b0;
      endcase
   endfunction

   always_ff @(posedge clk_usb_i) begin
      if (rst_i)
         err_q <= 1'b0;
      else if (reg_bus_i.wr) begin
         if (!addr_mapped(reg_bus_i.addr))
            err_q <= 1'b1;
         else if (reg_bus_i.addr == STATUS && reg_bus_i.wdata[STATUS_ERR_BIT])
            err_q <= 1'b0;   // Write 1 to clear
      end
   end

   always_ff @(posedge clk_usb_i) begin
      if (rst_i)
         read_data_o <= 8'h00;
      else if (reg_bus_i.rd) begin
         read_data_o <= 8'h00;
         if (reg_bus_i.addr == STATUS) begin
            read_data_o[STATUS_ERR_BIT] <= err_q;
            read_data_o[STATUS_PLL_BIT] <= pll_status_i;
         end
      end
   end

   // Free running, top bit sets the flash rate
   always_ff @(posedge clk_usb_i) begin
      if (rst_i)
         flash_cnt <= '0;
      else
         flash_cnt <= flash_cnt + 1'b1;
   end

   assign flash = flash_cnt[FLASH_BIT];

   always_ff @(posedge clk_usb_i) begin
      if (rst_i) begin
         led_adc_o    <= 1'b0;
         led_glitch_o <= 1'b0;
      end else begin
         led_adc_o    <= err_q ? flash : ~pll_status_i;
         led_glitch_o <= err_q ? flash : 1'b0;   // Off unless flashing
      end
   end

endmodule

`default_nettype wire

// File: hdl/target_pin_drive.sv
`timescale 1ns/1ps
`default_nettype none

module target_pin_drive
   import cw_pkg::*;
(
   input  wire target_ctrl_t target_ctrl_i,
   input  wire logic         sam_mosi_i,
   input  wire logic         sam_spck_i,
   input  wire logic         target_miso_i,
   output logic              target_nrst_o,
   output logic              target_nrst_oe_o,
   output logic              target_pdid_o,
   output logic              target_pdid_oe_o,
   output logic              target_pdic_o,
   output logic              target_pdic_oe_o,
   output logic              target_mosi_o,
   output logic              target_sck_o,
   output logic              target_spi_oe_o,
   output logic              sam_miso_o,
   output logic              sam_miso_oe_o,
   output logic              target_poweron_o
);

   logic target_highz;   // All target pins float when power is off

   assign target_highz     = target_ctrl_i.power_off;
   assign target_poweron_o = ~target_ctrl_i.power_off;

   // AVR programming holds the target in reset
   assign target_nrst_o    = target_ctrl_i.avrprog_en ? 1'b0 : target_ctrl_i.nrst_val;
   assign target_nrst_oe_o = ~target_highz &
                             (target_ctrl_i.avrprog_en | target_ctrl_i.nrst_en);

   assign target_pdid_o    = target_ctrl_i.pdid_val;
   assign target_pdid_oe_o = ~target_highz & target_ctrl_i.pdid_en;
   assign target_pdic_o    = target_ctrl_i.pdic_val;
   assign target_pdic_oe_o = ~target_highz & target_ctrl_i.pdic_en;

   // SPI from the SAM passes through only while programming
   assign target_mosi_o    = sam_mosi_i;
   assign target_sck_o     = sam_spck_i;
   assign target_spi_oe_o  = ~target_highz & target_ctrl_i.avrprog_en;

   // MISO back to the SAM ignores target power
   assign sam_miso_o       = target_miso_i;
   assign sam_miso_oe_o    = target_ctrl_i.avrprog_en;

endmodule

`default_nettype wire

// File: hdl/usb_reg_bus.sv
`timescale 1ns/1ps
`default_nettype none

module usb_reg_bus
   import cw_pkg::*;
(
   input  wire logic        clk_usb_i,
   input  wire logic        rst_i,
   input  wire logic [7:0]  usb_addr_i,
   input  wire logic [7:0]  usb_data_i,
   input  wire logic        usb_rdn_i,
   input  wire logic        usb_wrn_i,
   input  wire logic        usb_cen_i,
   input  wire logic [7:0]  read_data_i,   // OR of all block read bytes
   output logic      [7:0]  usb_data_o,
   output logic             usb_data_oe_o,
   output reg_bus_t         reg_bus_o
);

   logic [SYNC_STAGES-1:0] rdn_sync;
   logic [SYNC_STAGES-1:0] wrn_sync;
   logic [SYNC_STAGES-1:0] cen_sync;
   logic                   rdn_s;
   logic                   wrn_s;
   logic                   cen_s;
   logic                   rdn_last;
   logic                   wrn_last;
   logic                   rd_pulse;
   logic                   wr_pulse;
   logic                   rd_pulse_d;   // Block read bytes are valid here
   reg_addr_e              addr_q;
   logic [7:0]             wdata_q;

   assign rdn_s = rdn_sync[SYNC_STAGES-1];
   assign wrn_s = wrn_sync[SYNC_STAGES-1];
   assign cen_s = cen_sync[SYNC_STAGES-1];

   // Strobes idle high, so the chain resets to ones
   always_ff @(posedge clk_usb_i) begin
      if (rst_i) begin
         rdn_sync <= '1;
         wrn_sync <= '1;
         cen_sync <= '1;
         rdn_last <= 1'b1;
         wrn_last <= 1'b1;
      end else begin
         rdn_sync <= {rdn_sync[SYNC_STAGES-2:0], usb_rdn_i};
         wrn_sync <= {wrn_sync[SYNC_STAGES-2:0], usb_wrn_i};
         cen_sync <= {cen_sync[SYNC_STAGES-2:0], usb_cen_i};
         rdn_last <= rdn_s;
         wrn_last <= wrn_s;
      end
   end

   // Falling edge detect, qualified by chip enable
   always_ff @(posedge clk_usb_i) begin
      if (rst_i) begin
         rd_pulse   <= 1'b0;
         wr_pulse   <= 1'b0;
         rd_pulse_d <= 1'b0;
      end else begin
         rd_pulse   <= rdn_last & ~rdn_s & ~cen_s;
         wr_pulse   <= wrn_last & ~wrn_s & ~cen_s;
         rd_pulse_d <= rd_pulse;
      end
   end

   // Host keeps address and data stable while the strobe is low
   always_ff @(posedge clk_usb_i) begin
      addr_q  <= reg_addr_e'(usb_addr_i);
      wdata_q <= usb_data_i;
   end

   always_ff @(posedge clk_usb_i) begin
      if (rst_i)
         usb_data_o <= 8'h00;
      else if (rd_pulse_d)
         usb_data_o <= read_data_i;   // Held until the next read
   end

   assign usb_data_oe_o = ~rdn_s & ~cen_s;

   assign reg_bus_o = '{addr: addr_q, wdata: wdata_q, rd: rd_pulse, wr: wr_pulse};

endmodule

`default_nettype wire

// File: src.f
hdl/cw_pkg.sv
hdl/usb_reg_bus.sv
hdl/reg_target_io.sv
hdl/target_pin_drive.sv
hdl/reg_userio.sv
hdl/status_leds.sv
hdl/cw_top.sv
verification/cw_top_sva.sv
verification/tb_cw_top.sv

// File: verification/cw_stim.txt
# op addr data expect in hex; W write, X random write, R read, Q read random
# P inputs (addr userio, data pll miso spck mosi), T pins spi, O oe data, L leds
R 10 00 00
R 11 00 00
R 20 00 00
R 21 00 00
R 30 00 00
T 00 00 00
O 00 00 00
X 10 00 00
Q 10 00 00
X 11 00 00
Q 11 00 00
X 20 00 00
Q 20 00 00
X 21 00 00
Q 21 00 00
P 00 05 00
W 11 01 00
W 10 7F 00
T 00 85 0B
W 11 00 00
T 00 6F 0B
W 10 2E 00
T 00 2E 09
W 10 15 00
T 00 15 09
W 20 0F 00
W 21 5A 00
O 00 0F 0A
P C3 05 00
R 22 00 C3
W 55 00 00
R 30 00 01
L 00 01 00
W 30 01 00
R 30 00 00
P 00 0F 00
L 00 00 00
R 30 00 02

// File: verification/cw_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cw_top_sva
   import cw_pkg::*;
(
   input  wire logic         clk_usb_i,
   input  wire logic         rst_i,
   input  wire reg_bus_t     reg_bus_i,
   input  wire target_ctrl_t target_ctrl_i,
   input  wire logic         target_nrst_oe_i,
   input  wire logic         target_pdid_oe_i,
   input  wire logic         target_pdic_oe_i,
   input  wire logic         target_spi_oe_i
);

   int assert_fails = 0;   // Failed assertion count

   // Bus pulses from the strobe edge detect
   rd_one_cycle: assert property (@(posedge clk_usb_i) disable iff (rst_i)
      reg_bus_i.rd |=> !reg_bus_i.rd)
      else begin
         assert_fails++;
         $error("read pulse lasted more than one cycle");
      end

   wr_one_cycle: assert property (@(posedge clk_usb_i) disable iff (rst_i)
      reg_bus_i.wr |=> !reg_bus_i.wr)
      else begin
         assert_fails++;
         $error("write pulse lasted more than one cycle");
      end

   rd_wr_apart: assert property (@(posedge clk_usb_i) disable iff (rst_i)
      !(reg_bus_i.rd && reg_bus_i.wr))
      else begin
         assert_fails++;
         $error("read and write pulses in the same cycle");
      end

   // Powered down target sees only floating pins
   power_off_highz: assert property (@(posedge clk_usb_i) disable iff (rst_i)
      target_ctrl_i.power_off |->
         !(target_nrst_oe_i || target_pdid_oe_i || target_pdic_oe_i || target_spi_oe_i))
      else begin
         assert_fails++;
         $error("target pin enabled while power is off");
      end

endmodule

bind cw_top cw_top_sva u_cw_top_sva (
   .clk_usb_i        (clk_usb_i),
   .rst_i            (rst_i),
   .reg_bus_i        (reg_bus),
   .target_ctrl_i    (target_ctrl),
   .target_nrst_oe_i (target_nrst_oe_o),
   .target_pdid_oe_i (target_pdid_oe_o),
   .target_pdic_oe_i (target_pdic_oe_o),
   .target_spi_oe_i  (target_spi_oe_o)
);

`default_nettype wire

// File: verification/tb_cw_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cw_top
   import cw_pkg::*;
();

   localparam logic [31:0] SEED            = 32'h3440;
   localparam int          STROBE_LOW      = 6;
   localparam int          STROBE_HIGH     = 4;
   localparam int          WAIT_LIMIT      = 40;
   localparam int          LED_LIMIT       = 200;
   localparam int          WATCHDOG_CYCLES = 20000;

   logic                    clk_usb;
   logic                    rst;
   logic [7:0]              usb_addr;
   logic [7:0]              usb_data_in;
   logic                    usb_rdn;
   logic                    usb_wrn;
   logic                    usb_cen;
   logic                    pll_status;
   logic [USERIO_WIDTH-1:0] userio_in;
   logic                    sam_mosi;
   logic                    sam_spck;
   logic                    target_miso;
   logic [7:0]              usb_data_out;
   logic                    usb_data_oe;
   logic                    led_adc;
   logic                    led_glitch;
   logic [USERIO_WIDTH-1:0] userio_out;
   logic [USERIO_WIDTH-1:0] userio_oe;
   logic                    sam_miso;
   logic                    sam_miso_oe;
   logic                    target_mosi;
   logic                    target_sck;
   logic                    target_spi_oe;
   logic                    target_nrst;
   logic                    target_nrst_oe;
   logic                    target_pdid;
   logic                    target_pdid_oe;
   logic                    target_pdic;
   logic                    target_pdic_oe;
   logic                    target_poweron;

   logic [7:0] rand_bytes [256];   // Last random byte written per address
   bit         test_bad;
   int         test_count;
   int         pass_count;
   int         fail_count;

   cw_top DUT (
      .clk_usb_i        (clk_usb),
      .rst_i            (rst),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_data_in),
      .usb_data_o       (usb_data_out),
      .usb_data_oe_o    (usb_data_oe),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_cen_i        (usb_cen),
      .pll_status_i     (pll_status),
      .led_adc_o        (led_adc),
      .led_glitch_o     (led_glitch),
      .userio_d_i       (userio_in),
      .userio_d_o       (userio_out),
      .userio_oe_o      (userio_oe),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .sam_miso_o       (sam_miso),
      .sam_miso_oe_o    (sam_miso_oe),
      .target_miso_i    (target_miso),
      .target_mosi_o    (target_mosi),
      .target_sck_o     (target_sck),
      .target_spi_oe_o  (target_spi_oe),
      .target_nrst_o    (target_nrst),
      .target_nrst_oe_o (target_nrst_oe),
      .target_pdid_o    (target_pdid),
      .target_pdid_oe_o (target_pdid_oe),
      .target_pdic_o    (target_pdic),
      .target_pdic_oe_o (target_pdic_oe),
      .target_poweron_o (target_poweron)
   );

   initial begin
      clk_usb = 1'b0;
      forever #4 clk_usb = ~clk_usb;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_usb);
      $display("Simulation timed out before the stimulus file was finished");
      $display("TEST FAIL");
      $finish;
   end

   task automatic note_failure(input string msg);
      $display("%s", msg);
      test_bad = 1'b1;
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         test_bad = 1'b1;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         test_bad = 1'b1;
      end
   endtask

   task automatic check_pins(input target_ctrl_t got, input target_ctrl_t exp);
      if (got !== exp) begin
         $display("[ERROR] target_pins got %h expected %h", got, exp);
         test_bad = 1'b1;
      end
   endtask

   task automatic check_userio(input string name, input logic [USERIO_WIDTH-1:0] got,
                               input logic [USERIO_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         test_bad = 1'b1;
      end
   endtask

   // Pin enables and levels laid out like the control byte
   function automatic target_ctrl_t pins_now();
      target_ctrl_t p;
      p.power_off  = ~target_poweron;
      p.avrprog_en = target_spi_oe;
      p.nrst_en    = target_nrst_oe;
      p.nrst_val   = target_nrst;
      p.pdid_en    = target_pdid_oe;
      p.pdid_val   = target_pdid;
      p.pdic_en    = target_pdic_oe;
      p.pdic_val   = target_pdic;
      return p;
   endfunction

   function automatic logic [7:0] spi_now();
      return {4'h0, target_mosi, target_sck, sam_miso_oe, sam_miso};
   endfunction

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      @(negedge clk_usb);
      usb_addr    = addr;
      usb_data_in = data;
      usb_cen     = 1'b0;
      usb_wrn     = 1'b0;
      repeat (STROBE_LOW) @(negedge clk_usb);
      usb_wrn = 1'b1;
      usb_cen = 1'b1;
      repeat (STROBE_HIGH) @(negedge clk_usb);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      int waited;
      @(negedge clk_usb);
      usb_addr = addr;
      usb_cen  = 1'b0;
      usb_rdn  = 1'b0;
      waited   = 0;
      while (!usb_data_oe && waited < WAIT_LIMIT) begin
         @(negedge clk_usb);
         waited++;
      end
      if (!usb_data_oe)
         note_failure("Data bus output enable never rose during a read");
      repeat (STROBE_LOW - waited) @(negedge clk_usb);   // Keep the strobe low long enough
      usb_rdn = 1'b1;
      usb_cen = 1'b1;
      waited  = 0;
      while (usb_data_oe && waited < WAIT_LIMIT) begin
         @(negedge clk_usb);
         waited++;
      end
      if (usb_data_oe)
         note_failure("Data bus output enable stayed high after the read");
      data = usb_data_out;   // Held until the next read
      repeat (STROBE_HIGH) @(negedge clk_usb);
   endtask

   task automatic wait_led_flash();
      logic adc_start;
      logic glitch_start;
      bit   adc_seen;
      bit   glitch_seen;
      int   waited;
      @(negedge clk_usb);
      adc_start    = led_adc;
      glitch_start = led_glitch;
      adc_seen     = 1'b0;
      glitch_seen  = 1'b0;
      waited       = 0;
      while (!(adc_seen && glitch_seen) && waited < LED_LIMIT) begin
         @(negedge clk_usb);
         waited++;
         if (led_adc !== adc_start)
            adc_seen = 1'b1;
         if (led_glitch !== glitch_start)
            glitch_seen = 1'b1;
      end
      if (!(adc_seen && glitch_seen))
         note_failure("Status LEDs did not flash while the error was set");
   endtask

   // Without an error the ADC LED shows the inverted PLL lock
   task automatic check_leds_idle();
      repeat (2) @(negedge clk_usb);
      check_bit("led_adc_o", led_adc, ~pll_status);
      check_bit("led_glitch_o", led_glitch, 1'b0);
   endtask

   task automatic run_step(input logic [7:0] op, input logic [7:0] a,
                           input logic [7:0] d, input logic [7:0] e);
      logic [7:0]  got;
      logic [31:0] rnd;
      case (op)
         "W": bus_write(a, d);
         "X": begin
            rnd           = $urandom();
            rand_bytes[a] = rnd[7:0];
            bus_write(a, rand_bytes[a]);
         end
         "R": begin
            bus_read(a, got);
            check_byte("usb_data_o", got, e);
         end
         "Q": begin
            bus_read(a, got);
            check_byte("usb_data_o", got, rand_bytes[a]);
         end
         "P": begin
            @(negedge clk_usb);
            userio_in   = a;
            sam_mosi    = d[0];
            sam_spck    = d[1];
            target_miso = d[2];
            pll_status  = d[3];
         end
         "T": begin
            @(negedge clk_usb);
            check_pins(pins_now(), target_ctrl_t'(d));
            check_byte("target_spi", spi_now(), e);
         end
         "O": begin
            @(negedge clk_usb);
            check_userio("userio_oe_o", userio_oe, d);
            check_userio("userio_d_o", userio_out & userio_oe, e);   // Driven bits only
         end
         "L": begin
            if (d[0])
               wait_led_flash();
            else
               check_leds_idle();
         end
         default: note_failure("Unknown operation in the stimulus file");
      endcase
   endtask

   task automatic finish_test(input string label);
      test_count++;
      if (test_bad) begin
         fail_count++;
         $display("test %0d %s failed", test_count, label);
      end else begin
         pass_count++;
         $display("test %0d %s ok", test_count, label);
      end
   endtask

   initial begin
      int             fd;
      int             fields;
      logic [7:0]     op;
      logic [7:0]     a;
      logic [7:0]     d;
      logic [7:0]     e;
      logic [31:0]    seed_val;
      logic [8*128-1:0] rest;
      seed_val    = $urandom(SEED);
      test_count  = 0;
      pass_count  = 0;
      fail_count  = 0;
      rst         = 1'b1;
      usb_addr    = 8'h00;
      usb_data_in = 8'h00;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      usb_cen     = 1'b1;
      pll_status  = 1'b0;
      userio_in   = '0;
      sam_mosi    = 1'b0;
      sam_spck    = 1'b0;
      target_miso = 1'b0;
      repeat (3) @(negedge clk_usb);
      rst = 1'b0;

      // Idle state straight after reset
      test_bad = 1'b0;
      @(negedge clk_usb);
      check_bit("usb_data_oe_o", usb_data_oe, 1'b0);
      check_bit("target_poweron_o", target_poweron, 1'b1);
      check_userio("userio_oe_o", userio_oe, '0);
      finish_test("reset");

      fd = $fopen("verification/cw_stim.txt", "r");
      if (fd == 0) begin
         test_bad = 1'b1;
         $display("Could not open the stimulus file verification/cw_stim.txt");
         finish_test("stimulus file");
      end else begin
         while (!$feof(fd)) begin
            fields = $fscanf(fd, " %c", op);
            if (fields != 1)
               break;
            if (op == "#") begin
               fields = $fgets(rest, fd);   // Skip the comment text
            end else begin
               test_bad = 1'b0;
               fields   = $fscanf(fd, "%h %h %h", a, d, e);
               if (fields != 3)
                  note_failure("Stimulus line has fewer than three hex fields");
               else
                  run_step(op, a, d, e);
               finish_test($sformatf("%s %h %h %h", op, a, d, e));
            end
         end
         $fclose(fd);
      end

      $display("tests %0d passed %0d failed %0d", test_count, pass_count, fail_count);
      if (DUT.u_cw_top_sva.assert_fails != 0)
         $display("Bound assertions failed %0d times", DUT.u_cw_top_sva.assert_fails);
      if (fail_count == 0 && DUT.u_cw_top_sva.assert_fails == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
